// ==== verilog/mic_pkg.sv ====
// Shared types for the microprogram sequencer, imported by each RTL module that needs them.
package mic_pkg;

  typedef logic [12:0] maddr_t;   // Microaddress, 8K words of address space.
  typedef logic [11:0] csbits_t;  // Control-store bits, 11..4 high target, 3..0 micro-orders.
  typedef logic [3:0]  jmp_t;     // Jump field, low four target bits.
  typedef logic [19:0] mword_t;   // Packed microword as held in the store.

  // Field positions inside mword_t, most significant field first.
  localparam int MW_C20_BIT = 19;  // Single csbit20 bit.
  localparam int MW_CS_LSB  = 7;   // Control-store bits occupy 18..7.
  localparam int MW_JMP_LSB = 3;   // Jump field occupies 6..3.
  localparam int MW_OP_LSB  = 0;   // Sequencing operation occupies 2..0.

  // Sequencing operation carried in every microword.
  typedef enum logic [2:0] {
    OP_NEXT   = 3'd0,  // Fall through to W+1.
    OP_JUMP   = 3'd1,  // Unconditional jump.
    OP_CALL   = 3'd2,  // Jump and push return address.
    OP_RET    = 3'd3,  // Pop and return.
    OP_REPEAT = 3'd4,  // Back to the previously executed address.
    OP_BRANCH = 3'd5   // Jump when cond is high.
  } seq_op_e;

  // Source select, same order as the SC6:SC5 multiplexer inputs.
  typedef enum logic [1:0] {
    SEL_JUMP   = 2'd0,  // Assembled jump target.
    SEL_RET    = 2'd1,  // Top of return stack.
    SEL_NEXT   = 2'd2,  // Incremented address.
    SEL_REPEAT = 2'd3   // IW repeat register.
  } addr_sel_e;

endpackage

// ==== verilog/mic_word_if.sv ====
// Current microword fields, driven by the control store and read by the decoder and select.
interface mic_word_if
  import mic_pkg::*;
();

  logic    csbit20;  // Target bit 12.
  csbits_t csbit;    // Target bits 11..4 plus micro-orders.
  jmp_t    jmp;      // Target bits 3..0.
  seq_op_e seq_op;   // Sequencing operation.

  // Control store drives every field.
  modport store (
    output csbit20, csbit, jmp, seq_op
  );

  // Address select only needs the target fields.
  modport target (
    input csbit20, csbit, jmp
  );

  // Decoder only needs the operation.
  modport decode (
    input seq_op
  );

endinterface

// ==== verilog/mic_control_store.sv ====
// Writable microcode RAM; loaded through cs_we and read asynchronously at the current W.
module mic_control_store
  import mic_pkg::*;
#(
  parameter int CS_ADDR_BITS = 6  // Log2 of the store depth.
) (
  input  logic                    sysclk,
  input  logic                    cs_we,     // Write strobe.
  input  logic [CS_ADDR_BITS-1:0] cs_waddr,  // Write entry.
  input  mword_t                  cs_wdata,  // Packed microword to write.
  input  maddr_t                  w,         // Current microaddress.
  mic_word_if.store               word       // Unpacked current microword.
);

  localparam int CS_DEPTH = 2 ** CS_ADDR_BITS;

  mword_t mem [CS_DEPTH];  // Microword storage, loaded before use.
  mword_t rd_word;         // Word at the current address.
  logic [CS_ADDR_BITS-1:0] rd_addr;

  // Write port.
  always_ff @(posedge sysclk) begin
    if (cs_we) begin
      mem[cs_waddr] <= cs_wdata;  // Visible to the read after this edge.
    end
  end

  // Only the low address bits reach the RAM.
  assign rd_addr = w[CS_ADDR_BITS-1:0];
  assign rd_word = mem[rd_addr];  // Asynchronous read.

  // Split the packed word into its fields.
  assign word.csbit20 = rd_word[MW_C20_BIT];
  assign word.csbit   = rd_word[MW_CS_LSB +: $bits(csbits_t)];
  assign word.jmp     = rd_word[MW_JMP_LSB +: $bits(jmp_t)];
  assign word.seq_op  = seq_op_e'(rd_word[MW_OP_LSB +: $bits(seq_op_e)]);

endmodule

// ==== verilog/mic_seq_decode.sv ====
// Sequencing decoder; turns the microword operation and cond into source select and stack strobes.
module mic_seq_decode
  import mic_pkg::*;
(
  input  logic        mclk_en,  // Microcycle strobe.
  input  logic        cond,     // Branch condition.
  mic_word_if.decode  word,     // Current operation.
  output addr_sel_e   sel,      // Next-address source.
  output logic        push,     // Push return address.
  output logic        pop       // Pop return address.
);

  logic do_push;  // Operation wants a push.
  logic do_pop;   // Operation wants a pop.

  always_comb begin
    sel     = SEL_NEXT;  // Default is fall through.
    do_push = 1'b0;
    do_pop  = 1'b0;
    case (word.seq_op)
      OP_NEXT: begin
        sel = SEL_NEXT;
      end
      OP_JUMP: begin
        sel = SEL_JUMP;
      end
      OP_CALL: begin
        sel     = SEL_JUMP;  // Jump to the subroutine.
        do_push = 1'b1;      // Save W+1.
      end
      OP_RET: begin
        sel    = SEL_RET;  // Resume after the caller.
        do_pop = 1'b1;
      end
      OP_REPEAT: begin
        sel = SEL_REPEAT;
      end
      OP_BRANCH: begin
        sel = cond ? SEL_JUMP : SEL_NEXT;  // Taken only on cond.
      end
      default: begin
        sel = SEL_NEXT;  // Unused codes behave as NEXT.
      end
    endcase
  end

  // Stack moves only on a microcycle.
  assign push = do_push & mclk_en;
  assign pop  = do_pop & mclk_en;

endmodule

// ==== verilog/mic_return_stack.sv ====
// Circular return-address stack with the W+1 incrementer feeding both the stack and the select.
module mic_return_stack
  import mic_pkg::*;
#(
  parameter int STACK_DEPTH = 4  // Number of return entries.
) (
  input  logic   sysclk,
  input  logic   sys_rst_n,
  input  logic   push,       // Write next_addr and advance.
  input  logic   pop,        // Step back one entry.
  input  maddr_t w,          // Current microaddress.
  output maddr_t next_addr,  // W+1, wraps at 13 bits.
  output maddr_t ret_addr    // Entry below the pointer.
);

  localparam int PTR_W = (STACK_DEPTH > 1) ? $clog2(STACK_DEPTH) : 1;
  localparam logic [PTR_W-1:0] SP_LAST = PTR_W'(STACK_DEPTH - 1);

  typedef logic [PTR_W-1:0] sp_t;

  maddr_t stack [STACK_DEPTH];  // Return entries.
  sp_t    sp;                   // Next free entry.
  sp_t    sp_up;                // Pointer after a push.
  sp_t    sp_down;              // Pointer after a pop.

  assign next_addr = w + 13'd1;  // Natural wrap.

  // Wrap the pointer for any depth.
  assign sp_up   = (sp == SP_LAST) ? '0 : sp + 1'b1;
  assign sp_down = (sp == '0) ? SP_LAST : sp - 1'b1;

  assign ret_addr = stack[sp_down];  // Most recent push.

  always_ff @(posedge sysclk) begin
    if (!sys_rst_n) begin
      sp <= '0;
      for (int i = 0; i < STACK_DEPTH; i++) begin
        stack[i] <= '0;  // Empty stack returns to 0.
      end
    end else if (push) begin
      stack[sp] <= next_addr;  // Return lands after the call.
      sp        <= sp_up;      // Overflow overwrites the oldest.
    end else if (pop) begin
      sp <= sp_down;  // Underflow wraps around.
    end
  end

endmodule

// ==== verilog/mic_addr_select.sv ====
// Microaddress select; picks the next W from four sources and keeps the IW repeat register.
module mic_addr_select
  import mic_pkg::*;
(
  input  logic        sysclk,
  input  logic        sys_rst_n,
  input  logic        mclk_en,    // Microcycle strobe.
  input  addr_sel_e   sel,        // Source select.
  input  maddr_t      next_addr,  // W+1 from the stack block.
  input  maddr_t      ret_addr,   // Return address.
  mic_word_if.target  word,       // Jump target fields.
  output maddr_t      w,          // Current microaddress.
  output maddr_t      iw          // Previous microaddress.
);

  maddr_t jump_addr;  // Assembled jump target.
  maddr_t w_nxt;      // Selected source.

  // Bit 12 from csbit20, 11..4 from the store bits, 3..0 from jmp.
  assign jump_addr = {word.csbit20, word.csbit[11:4], word.jmp};

  // Four-way source mux.
  always_comb begin
    case (sel)
      SEL_JUMP:   w_nxt = jump_addr;
      SEL_RET:    w_nxt = ret_addr;
      SEL_NEXT:   w_nxt = next_addr;
      SEL_REPEAT: w_nxt = iw;  // Back to the last executed address.
      default:    w_nxt = next_addr;
    endcase
  end

  // W and IW advance together on each microcycle.
  always_ff @(posedge sysclk) begin
    if (!sys_rst_n) begin
      w  <= '0;  // Start at entry 0.
      iw <= '0;
    end else if (mclk_en) begin
      w  <= w_nxt;
      iw <= w;  // Keep the address just executed.
    end
  end

endmodule

// ==== verilog/mic_sequencer.sv ====
// Microprogram sequencer top; connects store, decoder, return stack and address select.
module mic_sequencer
  import mic_pkg::*;
#(
  parameter int CS_ADDR_BITS = 6,  // Log2 of the control-store depth.
  parameter int STACK_DEPTH  = 4   // Return stack entries.
) (
  input  logic                    sysclk,
  input  logic                    sys_rst_n,
  input  logic                    mclk_en,       // One-cycle microcycle strobe.
  input  logic                    cond,          // Branch condition.
  input  logic                    cs_we,         // Store write strobe.
  input  logic [CS_ADDR_BITS-1:0] cs_waddr,      // Store write entry.
  input  mword_t                  cs_wdata,      // Store write data.
  output maddr_t                  maddr,         // Current microaddress.
  output maddr_t                  iw,            // Previous microaddress.
  output logic [3:0]              micro_orders   // Low control-store bits.
);

  mic_word_if word_if ();  // Current microword.

  addr_sel_e sel;        // Decoder to select.
  logic      push;       // Decoder to stack.
  logic      pop;
  maddr_t    next_addr;  // Stack to select.
  maddr_t    ret_addr;
  maddr_t    w;          // Select to store and stack.

  assign maddr        = w;
  assign micro_orders = word_if.csbit[3:0];

  mic_control_store #(
    .CS_ADDR_BITS(CS_ADDR_BITS)
  ) store_i (
    .sysclk  (sysclk),
    .cs_we   (cs_we),
    .cs_waddr(cs_waddr),
    .cs_wdata(cs_wdata),
    .w       (w),
    .word    (word_if.store)
  );

  mic_seq_decode decode_i (
    .mclk_en(mclk_en),
    .cond   (cond),
    .word   (word_if.decode),
    .sel    (sel),
    .push   (push),
    .pop    (pop)
  );

  mic_return_stack #(
    .STACK_DEPTH(STACK_DEPTH)
  ) stack_i (
    .sysclk   (sysclk),
    .sys_rst_n(sys_rst_n),
    .push     (push),
    .pop      (pop),
    .w        (w),
    .next_addr(next_addr),
    .ret_addr (ret_addr)
  );

  mic_addr_select select_i (
    .sysclk   (sysclk),
    .sys_rst_n(sys_rst_n),
    .mclk_en  (mclk_en),
    .sel      (sel),
    .next_addr(next_addr),
    .ret_addr (ret_addr),
    .word     (word_if.target),
    .w        (w),
    .iw       (iw)
  );

endmodule

// ==== testbench/mic_sequencer_assert.sv ====
// Concurrent checks on the W and IW registers, bound into every mic_addr_select instance.
module mic_sequencer_assert
  import mic_pkg::*;
(
  input logic   sysclk,
  input logic   sys_rst_n,
  input logic   mclk_en,  // Microcycle strobe.
  input maddr_t w,        // Current microaddress.
  input maddr_t iw        // Previous microaddress.
);

  // Registers hold between microcycles.
  hold_without_strobe: assert property (@(posedge sysclk) disable iff (!sys_rst_n)
    !mclk_en |=> (w == $past(w)) && (iw == $past(iw)))
    else $error("W or IW changed while mclk_en was low");

  // IW captures the address that was just executed.
  iw_follows_w: assert property (@(posedge sysclk) disable iff (!sys_rst_n)
    mclk_en |=> iw == $past(w))
    else $error("IW does not hold the previous W after a microcycle");

  // Reset always lands at entry 0.
  w_zero_after_reset: assert property (@(posedge sysclk)
    !sys_rst_n |=> w == '0)
    else $error("W is not 0 one cycle after reset");

endmodule

bind mic_addr_select mic_sequencer_assert assert_i (
  .sysclk   (sysclk),
  .sys_rst_n(sys_rst_n),
  .mclk_en  (mclk_en),
  .w        (w),
  .iw       (iw)
);

// ==== testbench/tb_mic_sequencer.sv ====
// Testbench for the microprogram sequencer; loads random microcode and checks each cycle on a model.
module tb_mic_sequencer
  import mic_pkg::*;
();

  localparam int CS_ADDR_BITS = 6;
  localparam int STACK_DEPTH  = 4;
  localparam int CS_DEPTH     = 2 ** CS_ADDR_BITS;
  localparam int RUN_CYCLES   = 400;   // Random microcycles after the load.
  localparam int CYCLE_LIMIT  = 1000;  // Reset, load and run take under 500.

  logic                    sysclk;
  logic                    sys_rst_n;
  logic                    mclk_en;
  logic                    cond;
  logic                    cs_we;
  logic [CS_ADDR_BITS-1:0] cs_waddr;
  mword_t                  cs_wdata;
  maddr_t                  maddr;
  maddr_t                  iw;
  logic [3:0]              micro_orders;

  mword_t model_mem [CS_DEPTH];       // Copy of the control store.
  maddr_t model_stack [STACK_DEPTH];  // Copy of the return stack.
  int     model_sp;                   // Next free stack entry.
  maddr_t model_w;
  maddr_t model_iw;

  integer seed;
  int     error_cnt;
  int     check_cnt;
  int     cycle_cnt;
  int     call_cnt;
  int     ret_cnt;

  mic_sequencer #(
    .CS_ADDR_BITS(CS_ADDR_BITS),
    .STACK_DEPTH (STACK_DEPTH)
  ) dut_i (
    .sysclk      (sysclk),
    .sys_rst_n   (sys_rst_n),
    .mclk_en     (mclk_en),
    .cond        (cond),
    .cs_we       (cs_we),
    .cs_waddr    (cs_waddr),
    .cs_wdata    (cs_wdata),
    .maddr       (maddr),
    .iw          (iw),
    .micro_orders(micro_orders)
  );

  initial sysclk = 1'b0;
  always #10 sysclk = ~sysclk;  // 20 unit period.

  // Run limit.
  always @(posedge sysclk) begin
    cycle_cnt++;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // True about once in one_in draws.
  function automatic logic chance(int one_in);
    return ({$random(seed)} % one_in) == 0;
  endfunction

  // Sequencing operation with calls and returns kept rare.
  function automatic logic [2:0] draw_op();
    int pick;
    pick = {$random(seed)} % 16;
    if (pick < 5)       return OP_NEXT;
    else if (pick < 8)  return OP_JUMP;
    else if (pick < 11) return OP_BRANCH;
    else if (pick < 13) return OP_REPEAT;
    else if (pick == 13) return OP_CALL;
    else if (pick == 14) return OP_RET;
    else                return OP_NEXT;
  endfunction

  // Random csbit20, csbit and jmp fields above the operation.
  function automatic mword_t make_word();
    logic [31:0] rnd;
    logic [2:0]  op;
    rnd = $random(seed);
    op  = draw_op();
    return {rnd[16:0], op};
  endfunction

  // Bit 12 from csbit20, 11..4 from the high csbit field, 3..0 from jmp.
  function automatic maddr_t word_target(mword_t mw);
    return {mw[19], mw[18:11], mw[6:3]};
  endfunction

  task automatic check_outputs();
    mword_t cur;
    cur = model_mem[model_w[CS_ADDR_BITS-1:0]];
    check_cnt++;
    if (maddr !== model_w) begin
      error_cnt++;
      $display("FAIL at %0t: maddr %h, expected %h", $time, maddr, model_w);
    end
    if (iw !== model_iw) begin
      error_cnt++;
      $display("FAIL at %0t: iw %h, expected %h", $time, iw, model_iw);
    end
    if (micro_orders !== cur[10:7]) begin  // csbit bits 3..0.
      error_cnt++;
      $display("FAIL at %0t: micro_orders %h, expected %h", $time, micro_orders, cur[10:7]);
    end
  endtask

  // Predicts the state after the coming rising edge from the driven inputs.
  task automatic model_step();
    mword_t cur;
    maddr_t target;
    maddr_t nxt;
    cur    = model_mem[model_w[CS_ADDR_BITS-1:0]];
    target = word_target(cur);
    if (mclk_en) begin
      case (cur[2:0])
        OP_JUMP:   nxt = target;
        OP_CALL: begin
          model_stack[model_sp] = model_w + 13'd1;  // Resume after the caller.
          model_sp = (model_sp + 1) % STACK_DEPTH;
          nxt = target;
          call_cnt++;
        end
        OP_RET: begin
          model_sp = (model_sp + STACK_DEPTH - 1) % STACK_DEPTH;
          nxt = model_stack[model_sp];
          ret_cnt++;
        end
        OP_REPEAT: nxt = model_iw;
        OP_BRANCH: nxt = cond ? target : model_w + 13'd1;
        default:   nxt = model_w + 13'd1;
      endcase
      model_iw = model_w;
      model_w  = nxt;
    end
    if (cs_we) begin
      model_mem[cs_waddr] = cs_wdata;  // Read sees it after the edge.
    end
  endtask

  initial begin
    seed      = 86465;
    sys_rst_n = 1'b0;
    mclk_en   = 1'b0;
    cond      = 1'b0;
    cs_we     = 1'b0;
    cs_waddr  = '0;
    cs_wdata  = '0;
    error_cnt = 0;
    check_cnt = 0;
    cycle_cnt = 0;
    call_cnt  = 0;
    ret_cnt   = 0;
    model_sp  = 0;
    model_w   = '0;
    model_iw  = '0;
    for (int i = 0; i < STACK_DEPTH; i++) begin
      model_stack[i] = '0;
    end

    repeat (3) @(posedge sysclk);
    @(negedge sysclk);
    sys_rst_n = 1'b1;

    // Fill every store entry with mclk_en low.
    for (int i = 0; i < CS_DEPTH; i++) begin
      cs_we    = 1'b1;
      cs_waddr = CS_ADDR_BITS'(i);
      cs_wdata = make_word();
      model_mem[i] = cs_wdata;
      @(negedge sysclk);
    end
    cs_we = 1'b0;

    // Random microcycles with occasional store writes.
    for (int n = 0; n < RUN_CYCLES; n++) begin
      check_outputs();
      mclk_en = !chance(4);  // About 3 in 4.
      cond    = chance(2);
      cs_we   = chance(16);
      if (cs_we) begin
        cs_waddr = chance(2) ? model_w[CS_ADDR_BITS-1:0] : CS_ADDR_BITS'({$random(seed)});
        cs_wdata = make_word();
      end
      model_step();
      @(negedge sysclk);
    end
    mclk_en = 1'b0;
    cs_we   = 1'b0;
    check_outputs();

    $display("Checks: %0d, errors: %0d, calls: %0d, returns: %0d",
             check_cnt, error_cnt, call_cnt, ret_cnt);
    if (error_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== files.f ====
verilog/mic_pkg.sv
verilog/mic_word_if.sv
verilog/mic_control_store.sv
verilog/mic_seq_decode.sv
verilog/mic_return_stack.sv
verilog/mic_addr_select.sv
verilog/mic_sequencer.sv
testbench/mic_sequencer_assert.sv
testbench/tb_mic_sequencer.sv
